//--- sources.f
common/mem_port_pkg.sv
hdl/request_slot.sv
mem_dispatch/byte_sequencer.sv
mem_dispatch/read_assembler.sv
hdl/mem_dispatcher.sv
tests/tb_mem_dispatcher.sv

//--- Bender.yml
package:
  name: mem_dispatcher

sources:
  - common/mem_port_pkg.sv
  - hdl/request_slot.sv
  - mem_dispatch/byte_sequencer.sv
  - mem_dispatch/read_assembler.sv
  - hdl/mem_dispatcher.sv
  - target: test
    files:
      - tests/tb_mem_dispatcher.sv

//--- tests/dispatch_cases.txt
# group port(0 fetch 1 load 2 store 3 load+flush) size(0 byte 1 half 2 word)
# addr data expected check_expected, all hex except group, port, size and check
1 0 2 00000010 00000000 00000000 0
2 1 0 00000021 00000000 00000000 0
3 1 1 00000032 00000000 00000000 0
4 2 0 00000040 000000a5 00000000 0
5 1 0 00000040 00000000 000000a5 1
6 2 1 00000050 0000beef 00000000 0
7 1 1 00000050 00000000 0000beef 1
8 2 2 00000060 12345678 00000000 0
9 1 2 00000060 00000000 12345678 1
10 0 2 00000080 00000000 00000000 0
10 1 1 00000090 00000000 00000000 0
10 2 2 000000a0 cafef00d 00000000 0
11 1 2 000000a0 00000000 cafef00d 1
12 3 2 000000b0 00000000 00000000 0
13 1 2 000000b0 00000000 00000000 0
14 0 1 000000c2 00000000 00000000 0
14 1 0 000000c5 00000000 00000000 0
14 2 1 000000d0 00001234 00000000 0
15 1 1 000000d0 00000000 00001234 1

//--- tests/tb_mem_dispatcher.sv
/* mem_dispatcher testbench with clock, reset, byte memory model,
   case file replay and result checks */
module tb_mem_dispatcher
    import mem_port_pkg::*;
;

    localparam int max_cases = 64;
    localparam int mem_bytes = 256;

    logic                  in_clk;
    logic                  in_rst;
    logic                  in_flush;
    logic                  in_fetch_req;
    logic                  in_load_req;
    logic                  in_store_req;
    port_req_t             in_fetch;
    port_req_t             in_load;
    port_req_t             in_store;
    logic                  fetch_free;
    logic                  load_free;
    logic                  store_free;
    mem_cmd_t              mem_cmd;
    logic                  mem_valid;
    logic [byte_width-1:0] in_mem_data;
    logic [data_width-1:0] fetch_word;
    logic                  fetch_valid;
    logic [data_width-1:0] load_word;
    logic                  load_valid;

    logic [7:0]  mem [mem_bytes];      // memory seen by the DUT
    logic [7:0]  ref_mem [mem_bytes];  // expected contents
    int          case_grp [max_cases];
    int          case_port [max_cases];
    int          case_size [max_cases];
    logic [31:0] case_addr [max_cases];
    logic [31:0] case_data [max_cases];
    logic [31:0] case_exp [max_cases];
    int          case_fx [max_cases];
    int          n_cases;
    logic [31:0] fetch_q [$];
    logic [31:0] load_q [$];
    int          cmd_count;
    int          expected_cmds;
    int          value_errors;
    int          other_errors;
    int          cycles;
    int          cycle_limit;
    logic [31:0] rng;

    mem_dispatcher i_dut (.*);

    initial begin
        in_clk = 1'b0;
        forever #50 in_clk = ~in_clk;
    end

    // reads answer one cycle late and writes land on the command edge
    always @(posedge in_clk) begin
        if (mem_valid) begin
            cmd_count++;
            if (mem_cmd.we) begin
                mem[mem_cmd.addr[7:0]] = mem_cmd.wdata;
            end else begin
                in_mem_data <= mem[mem_cmd.addr[7:0]];
            end
        end
    end

    always @(posedge in_clk) begin
        if (fetch_valid) begin
            if (fetch_q.size() == 0) begin
                $display("unexpected fetch_valid pulse at time %0t", $time);
                other_errors++;
            end else begin
                check_value("fetch_word", fetch_word, fetch_q.pop_front());
            end
        end
        if (load_valid) begin
            if (load_q.size() == 0) begin
                $display("unexpected load_valid pulse at time %0t", $time);
                other_errors++;
            end else begin
                check_value("load_word", load_word, load_q.pop_front());
            end
        end
    end

    always @(posedge in_clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic load_cases();
        int    fd;
        string line;
        fd = $fopen("tests/dispatch_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/dispatch_cases.txt");
            other_errors++;
        end else begin
            while (!$feof(fd) && n_cases < max_cases) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%d %d %d %h %h %h %d", case_grp[n_cases],
                                case_port[n_cases], case_size[n_cases], case_addr[n_cases],
                                case_data[n_cases], case_exp[n_cases],
                                case_fx[n_cases]) == 7) begin
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // drives one request and updates the expected memory and words
    task automatic raise_request(input int idx, input logic [1:0] port);
        port_req_t   r;
        logic [31:0] word;
        int          nb;
        int          i;
        r.addr = case_addr[idx];
        r.size = access_size_t'(case_size[idx]);
        r.data = case_data[idx];
        nb     = byte_count(r.size);
        word   = '0;
        for (i = 0; i < nb; i++) begin
            if (port == port_store) begin
                ref_mem[8'(r.addr + i)] = r.data[8*i +: 8];
            end else begin
                word[8*i +: 8] = ref_mem[8'(r.addr + i)];
            end
        end
        expected_cmds += nb;
        if (case_fx[idx] != 0) begin
            check_value("case file word", word, case_exp[idx]);
        end
        case (port)
            port_fetch: begin
                in_fetch     = r;
                in_fetch_req = 1'b1;
                fetch_q.push_back(word);
            end
            port_load: begin
                in_load     = r;
                in_load_req = 1'b1;
                load_q.push_back(word);
            end
            default: begin
                in_store     = r;
                in_store_req = 1'b1;
            end
        endcase
    endtask

    task automatic drop_requests();
        in_fetch_req = 1'b0;
        in_load_req  = 1'b0;
        in_store_req = 1'b0;
    endtask

    task automatic wait_quiet();
        while (!(fetch_free && load_free && store_free &&
                 fetch_q.size() == 0 && load_q.size() == 0)) begin
            @(negedge in_clk);
        end
    endtask

    task automatic compare_memory();
        int a;
        for (a = 0; a < mem_bytes; a++) begin
            check_value($sformatf("mem[%0d]", a), mem[a], ref_mem[a]);
        end
    endtask

    task automatic run_group(input int first, output int next);
        int i;
        wait_quiet();
        @(negedge in_clk);
        cmd_count     = 0;
        expected_cmds = 0;
        i = first;
        while (i < n_cases && case_grp[i] == case_grp[first]) begin
            raise_request(i, 2'(case_port[i]));
            i++;
        end
        next = i;
        @(negedge in_clk);
        drop_requests();
        #1;
        for (i = first; i < next; i++) begin  // pending slots hold free low
            case (case_port[i])
                port_fetch: check_value("fetch_free", fetch_free, 1'b0);
                port_load:  check_value("load_free", load_free, 1'b0);
                default:    check_value("store_free", store_free, 1'b0);
            endcase
        end
        wait_quiet();
        repeat (4) @(negedge in_clk);  // room for stray pulses
        check_value("memory command count", cmd_count, expected_cmds);
        compare_memory();
    endtask

    // word load cut short by a flush during its second byte
    task automatic run_flush(input int idx);
        wait_quiet();
        @(negedge in_clk);
        raise_request(idx, port_load);
        @(negedge in_clk);
        drop_requests();
        @(negedge in_clk);
        in_flush = 1'b1;
        load_q.delete();
        @(negedge in_clk);
        in_flush = 1'b0;
        #1;
        // slots and sequencer already empty one edge after the flush
        check_value("fetch_free", fetch_free, 1'b1);
        check_value("load_free", load_free, 1'b1);
        check_value("store_free", store_free, 1'b1);
        check_value("mem_valid", mem_valid, 1'b0);
        repeat (4) @(negedge in_clk);
    endtask

    initial begin
        int idx;
        int next;
        int a;
        in_rst       = 1'b1;
        in_flush     = 1'b0;
        in_fetch_req = 1'b0;
        in_load_req  = 1'b0;
        in_store_req = 1'b0;
        in_fetch     = '0;
        in_load      = '0;
        in_store     = '0;
        in_mem_data <= '0;
        n_cases      = 0;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        cycle_limit  = 0;
        rng          = 32'ha4f9_4e70;
        for (a = 0; a < mem_bytes; a++) begin
            rng        = xorshift(rng);
            mem[a]     = rng[7:0] ^ 8'(a);
            ref_mem[a] = mem[a];
        end
        load_cases();
        if (n_cases == 0) begin
            $display("no cases were read from the case file");
            other_errors++;
        end
        cycle_limit = 40 * n_cases + 200;
        repeat (10) @(posedge in_clk);
        @(negedge in_clk);
        in_rst = 1'b0;
        idx = 0;
        while (idx < n_cases) begin
            if (case_port[idx] == 3) begin
                run_flush(idx);
                idx++;
            end else begin
                run_group(idx, next);
                idx = next;
            end
        end
        $display("checks done: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- hdl/mem_dispatcher.sv
/* memory dispatcher top: three request slots, byte sequencer
   and read assembler sharing one byte-wide memory */
module mem_dispatcher
    import mem_port_pkg::*;
(
    input  logic                  in_clk,
    input  logic                  in_rst,
    input  logic                  in_flush,

    input  logic                  in_fetch_req,
    input  logic                  in_load_req,
    input  logic                  in_store_req,
    input  port_req_t             in_fetch,
    input  port_req_t             in_load,
    input  port_req_t             in_store,
    output logic                  fetch_free,
    output logic                  load_free,
    output logic                  store_free,

    output mem_cmd_t              mem_cmd,
    output logic                  mem_valid,
    input  logic [byte_width-1:0] in_mem_data,

    output logic [data_width-1:0] fetch_word,
    output logic                  fetch_valid,
    output logic [data_width-1:0] load_word,
    output logic                  load_valid
);

    logic [num_ports-1:0]      req;
    port_req_t [num_ports-1:0] req_data;
    logic [num_ports-1:0]      free;
    logic [num_ports-1:0]      full;
    logic [num_ports-1:0]      done;
    port_req_t [num_ports-1:0] slot_data;

    logic                      rd_tag_valid;
    logic [1:0]                rd_tag_port;
    logic [1:0]                rd_tag_pos;
    logic                      rd_tag_last;

    // requester ports onto slot indices
    assign req[port_fetch]      = in_fetch_req;
    assign req[port_load]       = in_load_req;
    assign req[port_store]      = in_store_req;
    assign req_data[port_fetch] = in_fetch;
    assign req_data[port_load]  = in_load;
    assign req_data[port_store] = in_store;
    assign fetch_free           = free[port_fetch];
    assign load_free            = free[port_load];
    assign store_free           = free[port_store];

    for (genvar i = 0; i < num_ports; i++) begin : g_slot
        request_slot i_slot (
            .in_clk    (in_clk),
            .in_rst    (in_rst),
            .flush     (in_flush),
            .req       (req[i]),
            .req_data  (req_data[i]),
            .done      (done[i]),
            .full      (full[i]),
            .slot_data (slot_data[i]),
            .free      (free[i])
        );
    end

    byte_sequencer i_seq (
        .in_clk       (in_clk),
        .in_rst       (in_rst),
        .flush        (in_flush),
        .full         (full),
        .slot_data    (slot_data),
        .done         (done),
        .mem_cmd      (mem_cmd),
        .mem_valid    (mem_valid),
        .rd_tag_valid (rd_tag_valid),
        .rd_tag_port  (rd_tag_port),
        .rd_tag_pos   (rd_tag_pos),
        .rd_tag_last  (rd_tag_last)
    );

    read_assembler i_asm (
        .in_clk       (in_clk),
        .in_rst       (in_rst),
        .flush        (in_flush),
        .rd_tag_valid (rd_tag_valid),
        .rd_tag_port  (rd_tag_port),
        .rd_tag_pos   (rd_tag_pos),
        .rd_tag_last  (rd_tag_last),
        .mem_data     (in_mem_data),
        .fetch_word   (fetch_word),
        .fetch_valid  (fetch_valid),
        .load_word    (load_word),
        .load_valid   (load_valid)
    );

endmodule

//--- mem_dispatch/read_assembler.sv
/* read byte collection and fetch/load word delivery */
module read_assembler
    import mem_port_pkg::*;
(
    input  logic                  in_clk,
    input  logic                  in_rst,
    input  logic                  flush,
    input  logic                  rd_tag_valid,
    input  logic [1:0]            rd_tag_port,
    input  logic [1:0]            rd_tag_pos,
    input  logic                  rd_tag_last,
    input  logic [byte_width-1:0] mem_data,
    output logic [data_width-1:0] fetch_word,
    output logic                  fetch_valid,
    output logic [data_width-1:0] load_word,
    output logic                  load_valid
);

    logic                             tag_valid_q;
    logic [1:0]                       tag_port_q;
    logic [1:0]                       tag_pos_q;
    logic                             tag_last_q;
    logic [data_width-byte_width-1:0] shift_buf;  // newest byte on top
    logic [2:0]                       n_bytes;
    logic [data_width-1:0]            word;
    logic                             deliver;

    // tag lines up with the byte memory returns one cycle later
    always_ff @(posedge in_clk) begin
        if (in_rst || flush) begin
            tag_valid_q <= 1'b0;
        end else begin
            tag_valid_q <= rd_tag_valid;
        end
        tag_port_q <= rd_tag_port;
        tag_pos_q  <= rd_tag_pos;
        tag_last_q <= rd_tag_last;
    end

    always_ff @(posedge in_clk) begin
        if (tag_valid_q) begin
            shift_buf <= {mem_data, shift_buf[data_width-byte_width-1:byte_width]};
        end
    end

    always_comb begin
        n_bytes = {1'b0, tag_pos_q} + 3'd1;
        if (n_bytes == byte_count(size_word)) begin
            word = {mem_data, shift_buf};
        end else if (n_bytes == byte_count(size_half)) begin
            word = {16'd0, mem_data, shift_buf[data_width-byte_width-1 -: byte_width]};
        end else begin
            word = {24'd0, mem_data};
        end
    end

    assign deliver = tag_valid_q && tag_last_q && !flush;

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            fetch_valid <= 1'b0;
            load_valid  <= 1'b0;
        end else begin
            fetch_valid <= deliver && tag_port_q == port_fetch;
            load_valid  <= deliver && tag_port_q == port_load;
        end
        if (deliver && tag_port_q == port_fetch) begin
            fetch_word <= word;
        end
        if (deliver && tag_port_q == port_load) begin
            load_word <= word;
        end
    end

endmodule

//--- mem_dispatch/byte_sequencer.sv
/* rotating-priority grant over the request slots and
   byte-by-byte memory command generation */
module byte_sequencer
    import mem_port_pkg::*;
(
    input  logic                      in_clk,
    input  logic                      in_rst,
    input  logic                      flush,
    input  logic [num_ports-1:0]      full,
    input  port_req_t [num_ports-1:0] slot_data,
    output logic [num_ports-1:0]      done,
    output mem_cmd_t                  mem_cmd,
    output logic                      mem_valid,
    output logic                      rd_tag_valid,
    output logic [1:0]                rd_tag_port,
    output logic [1:0]                rd_tag_pos,
    output logic                      rd_tag_last
);

    logic                 busy;
    logic [1:0]           cur_port;  // last granted port, served while busy
    logic [1:0]           cnt;

    logic                 act_valid;
    logic [1:0]           act_port;
    logic [1:0]           act_cnt;
    logic                 act_last;
    logic [num_ports-1:0] act_sel;
    port_req_t            act_req;
    logic [2:0]           idle_pick;
    logic [2:0]           chain_pick;

    function automatic logic [1:0] next_port(input logic [1:0] p);
        if (p == port_store) begin
            return port_fetch;
        end
        return p + 2'd1;
    endfunction

    // {found, port}, searching the two ports after base, then base itself
    function automatic logic [2:0] rotate_pick(input logic [num_ports-1:0] mask,
                                               input logic [1:0]           base);
        logic [1:0] c1;
        logic [1:0] c2;
        c1 = next_port(base);
        c2 = next_port(c1);
        if (mask[c1]) begin
            return {1'b1, c1};
        end else if (mask[c2]) begin
            return {1'b1, c2};
        end else if (mask[base]) begin
            return {1'b1, base};
        end
        return 3'b000;
    endfunction

    always_comb begin
        // from idle the order is fetch, load, store
        idle_pick = rotate_pick(full, port_store);
        if (busy) begin
            act_valid = !flush;
            act_port  = cur_port;
            act_cnt   = cnt;
        end else begin
            act_valid = !flush && idle_pick[2];
            act_port  = idle_pick[1:0];
            act_cnt   = 2'd0;
        end
        act_req  = slot_data[act_port];
        act_last = ({1'b0, act_cnt} + 3'd1) == byte_count(act_req.size);

        act_sel           = '0;
        act_sel[act_port] = 1'b1;

        // next grant skips the slot that is finishing now
        chain_pick = rotate_pick(full & ~act_sel, act_port);
    end

    assign done = (act_valid && act_last) ? act_sel : '0;

    assign mem_valid     = act_valid;
    assign mem_cmd.addr  = act_req.addr + {{(addr_width-2){1'b0}}, act_cnt};
    assign mem_cmd.wdata = act_req.data[act_cnt*byte_width +: byte_width];
    assign mem_cmd.we    = act_port == port_store;

    // tag follows every read byte to the assembler
    assign rd_tag_valid = act_valid && !mem_cmd.we;
    assign rd_tag_port  = act_port;
    assign rd_tag_pos   = act_cnt;
    assign rd_tag_last  = act_last;

    always_ff @(posedge in_clk) begin
        if (in_rst || flush) begin
            busy     <= 1'b0;
            cur_port <= port_store;
            cnt      <= 2'd0;
        end else if (act_valid) begin
            if (act_last) begin
                // hand the memory straight to the next full slot
                busy     <= chain_pick[2];
                cur_port <= chain_pick[1:0];
                cnt      <= 2'd0;
            end else begin
                busy     <= 1'b1;
                cur_port <= act_port;
                cnt      <= act_cnt + 2'd1;
            end
        end
    end

endmodule

//--- hdl/request_slot.sv
/* one-entry request slot for a single requester */
module request_slot
    import mem_port_pkg::*;
(
    input  logic      in_clk,
    input  logic      in_rst,
    input  logic      flush,
    input  logic      req,
    input  port_req_t req_data,
    input  logic      done,
    output logic      full,
    output port_req_t slot_data,
    output logic      free
);

    // flush beats a request arriving in the same cycle
    always_ff @(posedge in_clk) begin
        if (in_rst || flush) begin
            full <= 1'b0;
        end else if (req) begin
            full <= 1'b1;
        end else if (done) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge in_clk) begin
        if (req) begin
            slot_data <= req_data;
        end
    end

    // requester may only raise req while this is high
    assign free = !full && !req;

endmodule

//--- common/mem_port_pkg.sv
/* shared widths, port indices, access sizes,
   request and memory command structs, byte_count helper */
package mem_port_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int byte_width = 8;
    localparam int num_ports  = 3;

    // slot index per requester, also the rotation order
    localparam logic [1:0] port_fetch = 2'd0;
    localparam logic [1:0] port_load  = 2'd1;
    localparam logic [1:0] port_store = 2'd2;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } access_size_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        access_size_t          size;
        logic [data_width-1:0] data;  // store data, unused for reads
    } port_req_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [byte_width-1:0] wdata;
        logic                  we;
    } mem_cmd_t;

    function automatic logic [2:0] byte_count(input access_size_t size);
        case (size)
            size_byte: byte_count = 3'd1;
            size_half: byte_count = 3'd2;
            default:   byte_count = 3'd4;
        endcase
    endfunction

endpackage
